// File: rtl/uart_pkg.sv
// UART package
// Widths, register map, status bit positions and FSM state encodings
`default_nettype none

package uart_pkg;

  localparam int unsigned DATA_WIDTH = 8;  // Character width
  localparam int unsigned BUS_WIDTH  = 32;  // Register bus width
  localparam int unsigned DIV_WIDTH  = 16;  // Baud divisor width

  localparam logic [DIV_WIDTH-1:0] DEFAULT_BAUD_DIV = 16'd16;  // Cycles per bit after reset

  typedef enum logic [1:0] {
    REG_DATA   = 2'd0,  // Write pushes tx FIFO, read pops rx FIFO
    REG_STATUS = 2'd1,  // Read-only flags, a write clears sticky errors
    REG_CTRL   = 2'd2,  // Bit 0 tx enable, bit 1 rx enable
    REG_BAUD   = 2'd3   // Baud divisor
  } reg_addr_e;

  typedef enum int unsigned {
    ST_TX_FULL   = 0,
    ST_TX_EMPTY  = 1,
    ST_RX_FULL   = 2,
    ST_RX_EMPTY  = 3,
    ST_TX_BUSY   = 4,
    ST_FRAME_ERR = 5,
    ST_OVERRUN   = 6
  } status_bit_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

`default_nettype wire

// File: rtl/uart_fifo_if.sv
// FIFO port bundle
// Push and pop sides of one byte FIFO, with the flags visible to both ends
`timescale 1ns/10ps
`default_nettype none

interface uart_fifo_if;
  import uart_pkg::*;

  logic                  push;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  full;
  logic                  pop;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  empty;

  // Both ends see both flags so the register block can report them
  modport writer (output push, output wdata, input full, input empty);
  modport reader (output pop, input rdata, input empty, input full);
  modport fifo (input push, input wdata, output full, input pop, output rdata, output empty);

endinterface

`default_nettype wire

// File: rtl/uart_fifo.sv
// Byte FIFO
// Synchronous first-in first-out buffer with full and empty flags from a count
`timescale 1ns/10ps
`default_nettype none

module uart_fifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  uart_fifo_if.fifo    fifo_if
);
  import uart_pkg::*;

  localparam int unsigned AW = $clog2(FIFO_DEPTH);

  logic [DATA_WIDTH-1:0] mem_q [FIFO_DEPTH];
  logic [AW-1:0]         wr_ptr_q;
  logic [AW-1:0]         rd_ptr_q;
  logic [AW:0]           count_q;
  logic                  do_push;
  logic                  do_pop;

  assign fifo_if.full  = (count_q == FIFO_DEPTH[AW:0]);
  assign fifo_if.empty = (count_q == '0);
  assign fifo_if.rdata = mem_q[rd_ptr_q];  // Oldest entry is always visible

  assign do_push = fifo_if.push && !fifo_if.full;
  assign do_pop  = fifo_if.pop && !fifo_if.empty;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Pointers wrap at the power-of-two depth
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Simultaneous push and pop leaves the count alone
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= fifo_if.wdata;
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
// UART receiver
// Synchronizes the serial line, samples 8N1 frames at mid-bit and
// pushes good bytes into the receive FIFO
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          rx_i,
  input  wire logic                          rx_en_i,
  input  wire logic [uart_pkg::DIV_WIDTH-1:0] baud_div_i,
  uart_fifo_if.writer                        fifo_if,
  output logic                               frame_err_o,
  output logic                               overrun_o
);
  import uart_pkg::*;

  localparam int unsigned IDX_W = $clog2(DATA_WIDTH);

  rx_state_e             state_q;
  logic                  rx_meta_q;
  logic                  rx_sync_q;
  logic                  rx_last_q;
  logic [DIV_WIDTH-1:0]  cnt_q;
  logic [DIV_WIDTH-1:0]  half_div;
  logic                  tick;
  logic [IDX_W-1:0]      bit_idx_q;
  logic [DATA_WIDTH-1:0] shift_q;
  logic                  push_q;
  logic                  frame_err_q;
  logic                  overrun_q;

  assign half_div = (baud_div_i >> 1) - 1'b1;  // Start edge to middle of start bit
  assign tick     = (cnt_q == '0);

  assign fifo_if.push  = push_q;
  assign fifo_if.wdata = shift_q;  // Shift register is stable while the push is pending
  assign frame_err_o   = frame_err_q;
  assign overrun_o     = overrun_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= RX_IDLE;
      rx_meta_q   <= 1'b1;  // Line idles high
      rx_sync_q   <= 1'b1;
      rx_last_q   <= 1'b1;
      cnt_q       <= '0;
      bit_idx_q   <= '0;
      push_q      <= 1'b0;
      frame_err_q <= 1'b0;
      overrun_q   <= 1'b0;
    end else begin
      rx_meta_q   <= rx_i;
      rx_sync_q   <= rx_meta_q;
      rx_last_q   <= rx_sync_q;
      push_q      <= 1'b0;
      frame_err_q <= 1'b0;
      overrun_q   <= 1'b0;
      if (!rx_en_i) begin
        state_q <= RX_IDLE;
      end else begin
        case (state_q)
          RX_IDLE: begin
            if (rx_last_q && !rx_sync_q) begin  // Falling edge marks a start bit
              cnt_q   <= half_div;
              state_q <= RX_START;
            end
          end
          RX_START: begin
            if (!tick) begin
              cnt_q <= cnt_q - 1'b1;
            end else if (!rx_sync_q) begin  // Still low at mid-bit, so a real start
              cnt_q     <= baud_div_i - 1'b1;
              bit_idx_q <= '0;
              state_q   <= RX_DATA;
            end else begin
              state_q <= RX_IDLE;  // Glitch on the line
            end
          end
          RX_DATA: begin
            if (!tick) begin
              cnt_q <= cnt_q - 1'b1;
            end else begin
              cnt_q     <= baud_div_i - 1'b1;
              bit_idx_q <= bit_idx_q + 1'b1;
              if (bit_idx_q == IDX_W'(DATA_WIDTH - 1)) state_q <= RX_STOP;
            end
          end
          RX_STOP: begin
            if (!tick) begin
              cnt_q <= cnt_q - 1'b1;
            end else begin
              // A good stop bit delivers the byte unless the FIFO has no room
              if (!rx_sync_q) frame_err_q <= 1'b1;
              else if (fifo_if.full) overrun_q <= 1'b1;
              else push_q <= 1'b1;
              state_q <= RX_IDLE;
            end
          end
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && tick) begin
      shift_q <= {rx_sync_q, shift_q[DATA_WIDTH-1:1]};  // LSB arrives first
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// UART transmitter
// Pops bytes from the transmit FIFO and shifts them out as 8N1 frames
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          tx_en_i,
  input  wire logic [uart_pkg::DIV_WIDTH-1:0] baud_div_i,
  uart_fifo_if.reader                        fifo_if,
  output logic                               tx_o,
  output logic                               busy_o
);
  import uart_pkg::*;

  localparam int unsigned IDX_W = $clog2(DATA_WIDTH);

  tx_state_e             state_q;
  logic [DIV_WIDTH-1:0]  cnt_q;
  logic                  tick;
  logic [IDX_W-1:0]      bit_idx_q;
  logic [DATA_WIDTH-1:0] shift_q;
  logic                  tx_q;
  logic                  load;
  logic                  shift_en;

  assign tick = (cnt_q == '0);

  // A new byte is taken when idle or right at the end of a stop bit
  assign load = tx_en_i && !fifo_if.empty &&
                (state_q == TX_IDLE || (state_q == TX_STOP && tick));

  assign shift_en = tick && (state_q == TX_START ||
                             (state_q == TX_DATA && bit_idx_q != IDX_W'(DATA_WIDTH - 1)));

  assign fifo_if.pop = load;
  assign tx_o        = tx_q;
  assign busy_o      = (state_q != TX_IDLE);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_q      <= 1'b1;  // Idle line is high
    end else begin
      if (load) begin
        tx_q    <= 1'b0;  // Start bit
        cnt_q   <= baud_div_i - 1'b1;
        state_q <= TX_START;
      end else if (!tick) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        case (state_q)
          TX_START: begin
            tx_q      <= shift_q[0];
            bit_idx_q <= '0;
            cnt_q     <= baud_div_i - 1'b1;
            state_q   <= TX_DATA;
          end
          TX_DATA: begin
            cnt_q <= baud_div_i - 1'b1;
            if (bit_idx_q == IDX_W'(DATA_WIDTH - 1)) begin
              tx_q    <= 1'b1;  // Stop bit
              state_q <= TX_STOP;
            end else begin
              tx_q      <= shift_q[0];
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end
          TX_STOP: state_q <= TX_IDLE;  // Nothing waiting, so the line rests
          default: state_q <= TX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= fifo_if.rdata;
    end else if (shift_en) begin
      shift_q <= shift_q >> 1;  // Next data bit moves into bit 0
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_ctrl.sv
// UART register block
// Decodes the four-register map, holds enables, divisor and sticky errors,
// and turns data-register accesses into FIFO pushes and pops
`timescale 1ns/10ps
`default_nettype none

module uart_ctrl (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           we_i,
  input  wire logic                           re_i,
  input  wire uart_pkg::reg_addr_e            addr_i,
  input  wire logic [uart_pkg::BUS_WIDTH-1:0] wdata_i,
  output logic      [uart_pkg::BUS_WIDTH-1:0] rdata_o,
  uart_fifo_if.writer                         tx_fifo,
  uart_fifo_if.reader                         rx_fifo,
  input  wire logic                           tx_busy_i,
  input  wire logic                           frame_err_i,
  input  wire logic                           overrun_i,
  output logic                                tx_en_o,
  output logic                                rx_en_o,
  output logic      [uart_pkg::DIV_WIDTH-1:0] baud_div_o
);
  import uart_pkg::*;

  logic                 tx_en_q;
  logic                 rx_en_q;
  logic [DIV_WIDTH-1:0] baud_div_q;
  logic                 frame_err_q;
  logic                 overrun_q;
  logic [BUS_WIDTH-1:0] rdata_q;
  logic [BUS_WIDTH-1:0] status;
  logic [BUS_WIDTH-1:0] read_val;
  logic                 status_wr;

  assign status_wr = we_i && (addr_i == REG_STATUS);

  // Full and empty FIFOs turn accesses into no-ops here, never in the FIFO
  assign tx_fifo.push  = we_i && (addr_i == REG_DATA) && !tx_fifo.full;
  assign tx_fifo.wdata = wdata_i[DATA_WIDTH-1:0];
  assign rx_fifo.pop   = re_i && (addr_i == REG_DATA) && !rx_fifo.empty;

  always_comb begin
    status               = '0;
    status[ST_TX_FULL]   = tx_fifo.full;
    status[ST_TX_EMPTY]  = tx_fifo.empty;
    status[ST_RX_FULL]   = rx_fifo.full;
    status[ST_RX_EMPTY]  = rx_fifo.empty;
    status[ST_TX_BUSY]   = tx_busy_i;
    status[ST_FRAME_ERR] = frame_err_q;
    status[ST_OVERRUN]   = overrun_q;
  end

  always_comb begin
    read_val = '0;
    case (addr_i)
      REG_DATA:   if (!rx_fifo.empty) read_val = BUS_WIDTH'(rx_fifo.rdata);
      REG_STATUS: read_val = status;
      REG_CTRL:   read_val = BUS_WIDTH'({rx_en_q, tx_en_q});
      REG_BAUD:   read_val = BUS_WIDTH'(baud_div_q);
      default:    read_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      tx_en_q     <= 1'b0;
      rx_en_q     <= 1'b0;
      baud_div_q  <= DEFAULT_BAUD_DIV;
      frame_err_q <= 1'b0;
      overrun_q   <= 1'b0;
      rdata_q     <= '0;
    end else begin
      if (we_i && addr_i == REG_CTRL) begin
        tx_en_q <= wdata_i[0];
        rx_en_q <= wdata_i[1];
      end
      if (we_i && addr_i == REG_BAUD) baud_div_q <= wdata_i[DIV_WIDTH-1:0];

      // A new error pulse wins over a clear in the same cycle
      if (frame_err_i) frame_err_q <= 1'b1;
      else if (status_wr) frame_err_q <= 1'b0;
      if (overrun_i) overrun_q <= 1'b1;
      else if (status_wr) overrun_q <= 1'b0;

      if (re_i) rdata_q <= read_val;  // Held until the next read
    end
  end

  assign rdata_o    = rdata_q;
  assign tx_en_o    = tx_en_q;
  assign rx_en_o    = rx_en_q;
  assign baud_div_o = baud_div_q;

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
// UART peripheral top level
// Register block, transmit and receive FIFOs and the two serial engines
`timescale 1ns/10ps
`default_nettype none

module uart_top #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic [1:0]                     addr_i,
  input  wire logic [uart_pkg::BUS_WIDTH-1:0] wdata_i,
  input  wire logic                           we_i,
  input  wire logic                           re_i,
  output logic      [uart_pkg::BUS_WIDTH-1:0] rdata_o,
  input  wire logic                           rx_i,
  output logic                                tx_o
);
  import uart_pkg::*;

  logic                 tx_en;
  logic                 rx_en;
  logic [DIV_WIDTH-1:0] baud_div;
  logic                 tx_busy;
  logic                 frame_err;
  logic                 overrun;

  uart_fifo_if tx_fifo ();
  uart_fifo_if rx_fifo ();

  uart_ctrl ctrl_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .we_i        (we_i),
    .re_i        (re_i),
    .addr_i      (reg_addr_e'(addr_i)),
    .wdata_i     (wdata_i),
    .rdata_o     (rdata_o),
    .tx_fifo     (tx_fifo.writer),
    .rx_fifo     (rx_fifo.reader),
    .tx_busy_i   (tx_busy),
    .frame_err_i (frame_err),
    .overrun_i   (overrun),
    .tx_en_o     (tx_en),
    .rx_en_o     (rx_en),
    .baud_div_o  (baud_div)
  );

  uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .fifo_if (tx_fifo.fifo)
  );

  uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .fifo_if (rx_fifo.fifo)
  );

  uart_tx tx_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tx_en_i    (tx_en),
    .baud_div_i (baud_div),
    .fifo_if    (tx_fifo.reader),
    .tx_o       (tx_o),
    .busy_o     (tx_busy)
  );

  uart_rx rx_i_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_i        (rx_i),
    .rx_en_i     (rx_en),
    .baud_div_i  (baud_div),
    .fifo_if     (rx_fifo.writer),
    .frame_err_o (frame_err),
    .overrun_o   (overrun)
  );

endmodule

`default_nettype wire

// File: dv/uart_tb.sv
// UART testbench
// Runs a table of loopback and bit-banged receive tests through the register bus,
// then measures the transmit start bit, with error counting and a watchdog
`timescale 1ns/10ps
`default_nettype none

module uart_tb;
  import uart_pkg::*;

  localparam int     CLK_PERIOD = 40;
  localparam int     DEPTH      = 8;
  localparam int     NUM_TESTS  = 4;
  localparam longint MARGIN_NS  = 40000;  // Reset, bus polling and the start-bit check

  // One column per field, one index per test
  localparam int TEST_DIV   [NUM_TESTS] = '{8, 13, 10, 8};
  localparam int TEST_COUNT [NUM_TESTS] = '{5, 6, 1, 9};
  localparam bit TEST_BAD   [NUM_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b0};
  localparam bit TEST_LOOP  [NUM_TESTS] = '{1'b1, 1'b1, 1'b0, 1'b0};
  string test_name [NUM_TESTS] = '{"loopback_div8", "loopback_div13", "bad_stop",
                                   "rx_overrun"};

  logic        clk_i;
  logic        rst_ni;
  logic [1:0]  addr;
  logic [31:0] wdata;
  logic        we;
  logic        re;
  logic [31:0] rdata;
  logic        tx_line;
  logic        rx_line;
  logic        bb_line;
  logic        use_bitbang;
  logic [31:0] rng_state;
  logic [7:0]  sent_q [$];
  int          error_count;
  int          check_count;

  uart_top #(.FIFO_DEPTH(DEPTH)) uart_top_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .addr_i  (addr),
    .wdata_i (wdata),
    .we_i    (we),
    .re_i    (re),
    .rdata_o (rdata),
    .rx_i    (rx_line),
    .tx_o    (tx_line)
  );

  assign rx_line = use_bitbang ? bb_line : tx_line;  // Loopback unless frames are bit-banged

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] status_mask(input status_bit_e b);
    return 32'd1 << b;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic bus_write(input logic [1:0] a, input logic [31:0] d);
    @(negedge clk_i);
    addr  = a;
    wdata = d;
    we    = 1'b1;
    @(negedge clk_i);
    we = 1'b0;
  endtask

  task automatic bus_read(input logic [1:0] a, output logic [31:0] d);
    @(negedge clk_i);
    addr = a;
    re   = 1'b1;
    @(negedge clk_i);
    re = 1'b0;
    d  = rdata;  // Registered one cycle after the strobe
  endtask

  task automatic wait_rx_data();
    logic [31:0] st;
    bus_read(REG_STATUS, st);
    while ((st & status_mask(ST_RX_EMPTY)) != 0) bus_read(REG_STATUS, st);
  endtask

  task automatic send_frame(input logic [7:0] data, input bit bad_stop, input int div);
    logic [7:0] sh;
    sh = data;
    @(negedge clk_i);
    bb_line = 1'b0;  // Start bit
    repeat (div) @(negedge clk_i);
    repeat (8) begin
      bb_line = sh[0];  // LSB first
      sh      = sh >> 1;
      repeat (div) @(negedge clk_i);
    end
    bb_line = ~bad_stop;
    repeat (div) @(negedge clk_i);
    bb_line = 1'b1;
    repeat (div) @(negedge clk_i);  // One idle bit between frames
  endtask

  task automatic measure_start_bit(output int cycles);
    cycles = 0;
    do @(negedge clk_i); while (tx_line !== 1'b0);
    while (tx_line === 1'b0) begin
      cycles++;
      @(negedge clk_i);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] exp_status;
    int          delivered;
    int          cycles;
    int          t;
    int          i;
    rst_ni      = 1'b0;
    addr        = 2'd0;
    wdata       = '0;
    we          = 1'b0;
    re          = 1'b0;
    bb_line     = 1'b1;
    use_bitbang = 1'b0;
    error_count = 0;
    check_count = 0;
    rng_state   = 32'd37103;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    check_value("reset rdata", 32'd0, rdata);
    check_value("reset tx line", 32'd1, {31'd0, tx_line});
    bus_read(REG_STATUS, rd);
    check_value("reset status", status_mask(ST_TX_EMPTY) | status_mask(ST_RX_EMPTY), rd);
    bus_read(REG_BAUD, rd);
    check_value("reset baud", 32'd16, rd);

    for (t = 0; t < NUM_TESTS; t++) begin
      use_bitbang = ~TEST_LOOP[t];
      bus_write(REG_BAUD, TEST_DIV[t]);
      bus_write(REG_CTRL, 32'd3);  // Both directions on
      sent_q.delete();
      repeat (TEST_COUNT[t]) begin
        rng_state = xorshift32(rng_state);
        sent_q.push_back(rng_state[7:0]);
      end
      if (TEST_LOOP[t]) begin
        for (i = 0; i < sent_q.size(); i++) bus_write(REG_DATA, {24'd0, sent_q[i]});
      end else begin
        for (i = 0; i < sent_q.size(); i++) send_frame(sent_q[i], TEST_BAD[t], TEST_DIV[t]);
      end
      delivered = TEST_BAD[t] ? 0 : (TEST_COUNT[t] > DEPTH ? DEPTH : TEST_COUNT[t]);

      if (!TEST_LOOP[t]) begin
        exp_status = status_mask(ST_TX_EMPTY);
        if (delivered == 0) exp_status |= status_mask(ST_RX_EMPTY);
        if (delivered == DEPTH) exp_status |= status_mask(ST_RX_FULL);
        if (TEST_BAD[t]) exp_status |= status_mask(ST_FRAME_ERR);
        if (!TEST_BAD[t] && TEST_COUNT[t] > DEPTH) exp_status |= status_mask(ST_OVERRUN);
        bus_read(REG_STATUS, rd);
        check_value({test_name[t], " status"}, exp_status, rd);
      end

      for (i = 0; i < delivered; i++) begin
        wait_rx_data();
        bus_read(REG_DATA, rd);
        check_value($sformatf("%s byte %0d", test_name[t], i), {24'd0, sent_q[i]}, rd);
      end
      bus_read(REG_DATA, rd);
      check_value({test_name[t], " empty read"}, 32'd0, rd);

      bus_write(REG_STATUS, 32'd0);  // Clears the sticky errors
      bus_read(REG_STATUS, rd);
      check_value({test_name[t], " sticky clear"}, 32'd0,
                  rd & (status_mask(ST_FRAME_ERR) | status_mask(ST_OVERRUN)));
    end

    // Bytes wait in the transmit FIFO before tx is enabled, bit 0 high ends the start bit
    use_bitbang = 1'b0;
    bus_write(REG_CTRL, 32'd2);
    bus_write(REG_BAUD, 32'd11);
    bus_write(REG_DATA, 32'h55);
    bus_write(REG_DATA, 32'h55);
    fork
      measure_start_bit(cycles);
      bus_write(REG_CTRL, 32'd3);
    join
    check_value("start bit length", 32'd11, cycles);
    for (i = 0; i < 2; i++) begin
      wait_rx_data();
      bus_read(REG_DATA, rd);
      check_value($sformatf("start bit byte %0d", i), 32'h55, rd);
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    longint limit_ns;
    int     t;
    limit_ns = MARGIN_NS;
    for (t = 0; t < NUM_TESTS; t++) begin
      limit_ns += longint'(2 * TEST_COUNT[t] * 10 * TEST_DIV[t] * CLK_PERIOD);
    end
    #(limit_ns);
    $display("Timeout: the tests did not finish within %0d ns", limit_ns);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/uart_pkg.sv
rtl/uart_fifo_if.sv
rtl/uart_fifo.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_ctrl.sv
rtl/uart_top.sv
dv/uart_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the UART testbench with Verilator, runs it and judges the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
  -f project.f \
  --top-module uart_tb \
  -o uart_tb_sim

./obj_dir/uart_tb_sim | tee "$LOG"

if grep -q "Regression failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

echo "Simulation finished without a reported failure"
